/* build.f */
hw/rv_isa_pkg.sv
hw/cpu_bus_pkg.sv
hw/gpr.sv
hw/ifu.sv
hw/idu.sv
hw/exu.sv
hw/cpu_top.sv
tb/tb_cpu_top.sv

/* Makefile */
TOP := tb_cpu_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

obj_dir/V$(TOP): build.f hw/*.sv tb/*.sv
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Done: errors found" sim.log; then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "Done: no errors" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* tb/tb_cpu_top.sv */
// RESET_PC is 0x100 in a 256-word memory and every program must end in jal x0,0
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam int          SETTLE   = 12;
    localparam logic [31:0] HALT     = 32'h0000_006f;

    localparam logic [6:0] OPC_R   = 7'h33;
    localparam logic [6:0] OPC_I   = 7'h13;
    localparam logic [6:0] OPC_LUI = 7'h37;
    localparam logic [6:0] OPC_JAL = 7'h6f;
    localparam logic [6:0] OPC_BR  = 7'h63;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // AXI prot for an instruction, secure, unprivileged access
    localparam logic [2:0] PROT_FETCH = 3'b100;

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    cpu_bus_pkg::axil_ar_t ar_o;
    logic                  arvalid_o;
    logic                  arready_i;
    cpu_bus_pkg::axil_r_t  r_i;
    logic                  rvalid_i;
    logic                  rready_o;
    cpu_bus_pkg::commit_t  commit_o;

    logic [31:0]          mem [0:255];
    logic [31:0]          ref_regs [0:31];
    cpu_bus_pkg::commit_t exp_q [$];
    cpu_bus_pkg::commit_t exp_c;

    // memory model state
    logic        bus_rst = 1'b1;
    logic        ar_fire = 1'b0;
    logic        r_fire = 1'b0;
    logic [31:0] ar_addr_q;
    logic [31:0] req_addr;
    logic        req_pending;
    int          ar_delay;
    int          r_delay;
    logic        stall_en;
    logic [31:0] lcg_state = 32'd55;
    logic        first_ar_seen;
    logic [31:0] first_ar_addr;

    string name_cur;
    int    wr_idx;
    int    n_prog;
    int    test_num = 0;
    int    tests_failed = 0;
    int    test_errs = 0;
    int    total_errs = 0;
    int    cycle_cnt;
    int    cycle_limit = 20;

    cpu_top #(
        .RESET_PC(RESET_PC)
    ) cpu_top_inst (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .ar_o     (ar_o),
        .arvalid_o(arvalid_o),
        .arready_i(arready_i),
        .r_i      (r_i),
        .rvalid_i (rvalid_i),
        .rready_o (rready_o),
        .commit_o (commit_o)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // 0 to 3 cycles taken from the upper LCG bits
    function automatic int pick_delay();
        logic [31:0] r;
        r = next_rand();
        return stall_en ? int'(r[17:16]) : 0;
    endfunction

    // unused words hold a custom-0 opcode tagged with their byte address
    function automatic logic [31:0] fill_word(int idx);
        return {idx[22:0], 2'b00, 7'h0b};
    endfunction

    function automatic logic [31:0] enc_r(int f7, logic [2:0] f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_R};
    endfunction

    function automatic logic [31:0] enc_i(logic [2:0] f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], OPC_I};
    endfunction

    function automatic logic [31:0] enc_lui(int rd, int imm);
        return {imm[19:0], rd[4:0], OPC_LUI};
    endfunction

    function automatic logic [31:0] enc_jal(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic logic [31:0] enc_br(logic [2:0] f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BR};
    endfunction

    // bit 32 set when the funct3 is one this core writes back
    function automatic logic [32:0] alu_ref(logic [2:0] f3, logic sub, logic [31:0] a,
                                           logic [31:0] b);
        case (f3)
            F3_ADD:  return {1'b1, sub ? a - b : a + b};
            F3_SLT:  return {1'b1, 31'd0, $signed(a) < $signed(b)};
            F3_XOR:  return {1'b1, a ^ b};
            F3_OR:   return {1'b1, a | b};
            F3_AND:  return {1'b1, a & b};
            default: return 33'd0;
        endcase
    endfunction

    // ISA model from start_pc up to the halt word, filling exp_q
    function automatic void ref_run(logic [31:0] start_pc);
        logic [31:0]          pc;
        logic [31:0]          inst;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [31:0]          res;
        logic [31:0]          nxt;
        logic [31:0]          imm_i;
        logic [31:0]          imm_b;
        logic [31:0]          imm_j;
        logic                 wr;
        logic [2:0]           f3;
        cpu_bus_pkg::commit_t c;
        int                   steps;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        pc    = start_pc;
        steps = 0;
        inst  = mem[pc[9:2]];
        while (inst != HALT && steps < 1000) begin
            a     = ref_regs[inst[19:15]];
            b     = ref_regs[inst[24:20]];
            f3    = inst[14:12];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            wr    = 1'b0;
            res   = '0;
            nxt   = pc + 32'd4;
            case (inst[6:0])
                OPC_R:   {wr, res} = alu_ref(f3, inst[31:25] == 7'h20, a, b);
                OPC_I:   {wr, res} = alu_ref(f3, 1'b0, a, imm_i);
                OPC_LUI: begin
                    wr  = 1'b1;
                    res = {inst[31:12], 12'h000};
                end
                OPC_JAL: begin
                    wr  = 1'b1;
                    res = pc + 32'd4;
                    nxt = pc + imm_j;
                end
                OPC_BR: begin
                    if ((f3 == F3_BEQ && a == b) || (f3 == F3_BNE && a != b)) begin
                        nxt = pc + imm_b;
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && inst[11:7] != 5'd0) begin
                ref_regs[inst[11:7]] = res;
                c = '{valid: 1'b1, pc: pc, rd: inst[11:7], data: res};
                exp_q.push_back(c);
            end
            pc    = nxt;
            inst  = mem[pc[9:2]];
            steps = steps + 1;
        end
    endfunction

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
            test_errs = test_errs + 1;
        end
    endtask

    // handshakes as seen at the rising edge
    always @(posedge clk) begin
        bus_rst <= !rst_n_i;
        ar_fire <= rst_n_i && arvalid_o && arready_i;
        r_fire  <= rst_n_i && rvalid_i && rready_o;
        if (arvalid_o && arready_i) begin
            ar_addr_q <= ar_o.addr;
        end
        if (rst_n_i && arvalid_o && arready_i) begin
            check_value("ar_o.prot", {29'd0, ar_o.prot}, {29'd0, PROT_FETCH});
        end
        if (!rst_n_i) begin
            first_ar_seen <= 1'b0;
        end else if (arvalid_o && arready_i && !first_ar_seen) begin
            first_ar_seen <= 1'b1;
            first_ar_addr <= ar_o.addr;
        end
    end

    // memory model drives on the falling edge
    always @(negedge clk) begin
        if (bus_rst) begin
            arready_i   = 1'b0;
            rvalid_i    = 1'b0;
            r_i         = '0;
            req_pending = 1'b0;
            ar_delay    = 0;
            r_delay     = 0;
        end else begin
            if (r_fire) begin
                rvalid_i    = 1'b0;
                req_pending = 1'b0;
            end
            if (ar_fire) begin
                arready_i   = 1'b0;
                req_pending = 1'b1;
                req_addr    = ar_addr_q;
                r_delay     = pick_delay();
            end else if (arvalid_o && !arready_i && !req_pending) begin
                if (ar_delay == 0) begin
                    arready_i = 1'b1;
                    ar_delay  = pick_delay();
                end else begin
                    ar_delay = ar_delay - 1;
                end
            end
            if (req_pending && !rvalid_i) begin
                if (r_delay == 0) begin
                    rvalid_i = 1'b1;
                    r_i      = '{data: mem[req_addr[9:2]], resp: 2'b00};
                end else begin
                    r_delay = r_delay - 1;
                end
            end
        end
    end

    // commit checker, in order against the reference queue
    always @(posedge clk) begin
        if (rst_n_i && commit_o.valid) begin
            if (exp_q.size() == 0) begin
                $display("error at %0t: commit from pc %h to x%0d was not expected",
                         $time, commit_o.pc, commit_o.rd);
                test_errs = test_errs + 1;
            end else begin
                exp_c = exp_q.pop_front();
                check_value("commit_o.pc", commit_o.pc, exp_c.pc);
                check_value("commit_o.rd", {27'd0, commit_o.rd}, {27'd0, exp_c.rd});
                check_value("commit_o.data", commit_o.data, exp_c.data);
            end
        end
    end

    task automatic emit(logic [31:0] word);
        mem[wr_idx] = word;
        wr_idx      = wr_idx + 1;
        n_prog      = n_prog + 1;
    endtask

    // holds reset for 16 cycles and leaves a cleared memory to build into
    task automatic begin_test(string name, logic stalls);
        cycle_limit = cycle_limit + 20;
        @(negedge clk);
        rst_n_i   = 1'b0;
        stall_en  = stalls;
        name_cur  = name;
        test_num  = test_num + 1;
        test_errs = 0;
        repeat (16) begin
            @(posedge clk);
            @(negedge clk);
            check_value("commit_o.valid", {31'd0, commit_o.valid}, 32'd0);
            check_value("rready_o", {31'd0, rready_o}, 32'd0);
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        wr_idx = int'(RESET_PC[9:2]);
        n_prog = 0;
    endtask

    task automatic end_test();
        int waited;
        ref_run(RESET_PC);
        cycle_limit = cycle_limit + 12 * n_prog + SETTLE;
        rst_n_i = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_value("commit_o.valid", {31'd0, commit_o.valid}, 32'd0);
        check_value("rready_o", {31'd0, rready_o}, 32'd0);
        waited = 0;
        while (exp_q.size() != 0 && waited < 12 * n_prog) begin
            @(posedge clk);
            waited = waited + 1;
        end
        repeat (SETTLE) @(posedge clk);
        @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("error: %0d expected commits never appeared", exp_q.size());
            test_errs = test_errs + 1;
            exp_q.delete();
        end
        if (!first_ar_seen) begin
            $display("error: no AR was accepted after reset");
            test_errs = test_errs + 1;
        end else begin
            check_value("ar_o.addr", first_ar_addr, RESET_PC);
        end
        if (test_errs != 0) begin
            tests_failed = tests_failed + 1;
        end
        total_errs = total_errs + test_errs;
        $display("test %0d %s: %s (%0d mismatches)", test_num, name_cur,
                 (test_errs == 0) ? "pass" : "FAIL", test_errs);
    endtask

    // taken and untaken branches and jumps, with wrong-path words after each taken one
    task automatic load_branch_prog();
        emit(enc_i(F3_ADD, 1, 0, 3));
        emit(enc_i(F3_ADD, 2, 0, 3));
        emit(enc_br(F3_BEQ, 1, 2, 12));
        emit(enc_i(F3_ADD, 10, 0, 1));
        emit(enc_i(F3_ADD, 11, 0, 1));
        emit(enc_br(F3_BNE, 1, 2, 8));
        emit(enc_i(F3_ADD, 3, 0, 9));
        emit(enc_br(F3_BNE, 1, 3, 12));
        emit(enc_i(F3_ADD, 12, 0, 1));
        emit(enc_i(F3_ADD, 13, 0, 1));
        emit(enc_br(F3_BEQ, 1, 3, 8));
        emit(enc_jal(5, 12));
        emit(enc_i(F3_ADD, 14, 0, 1));
        emit(enc_i(F3_ADD, 15, 0, 1));
        emit(enc_r(0, F3_ADD, 6, 5, 1));
        emit(enc_jal(0, 8));
        emit(enc_i(F3_ADD, 16, 0, 1));
        // backward loop, three passes
        emit(enc_i(F3_ADD, 7, 7, 1));
        emit(enc_br(F3_BNE, 7, 1, -4));
        emit(HALT);
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout: run still going after %0d cycles", cycle_cnt);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst_n_i   = 1'b0;
        arready_i = 1'b0;
        rvalid_i  = 1'b0;
        r_i       = '0;
        stall_en  = 1'b0;

        begin_test("reset and first fetch", 1'b0);
        emit(enc_i(F3_ADD, 1, 0, 5));
        emit(enc_i(F3_ADD, 2, 1, 7));
        emit(HALT);
        end_test();

        begin_test("register ALU", 1'b0);
        emit(enc_i(F3_ADD, 1, 0, 100));
        emit(enc_i(F3_ADD, 2, 0, -7));
        emit(enc_lui(3, 'h80000));
        emit(enc_r(0, F3_ADD, 4, 1, 2));
        emit(enc_r(32, F3_ADD, 5, 2, 1));
        emit(enc_r(0, F3_AND, 6, 1, 2));
        emit(enc_r(0, F3_OR, 7, 1, 2));
        emit(enc_r(0, F3_XOR, 8, 1, 2));
        // signed compares with negative operands
        emit(enc_r(0, F3_SLT, 9, 2, 1));
        emit(enc_r(0, F3_SLT, 10, 1, 2));
        emit(enc_r(0, F3_SLT, 11, 3, 2));
        emit(enc_r(32, F3_ADD, 12, 0, 1));
        emit(enc_r(0, F3_ADD, 13, 3, 3));
        emit(HALT);
        end_test();

        begin_test("immediates, LUI and x0", 1'b0);
        emit(enc_i(F3_ADD, 1, 0, -1));
        emit(enc_i(F3_AND, 2, 1, 'h0f0));
        emit(enc_i(F3_OR, 3, 0, -2048));
        emit(enc_i(F3_XOR, 4, 1, 'h555));
        emit(enc_i(F3_SLT, 5, 1, 0));
        emit(enc_i(F3_SLT, 6, 0, -1));
        emit(enc_lui(7, 'habcde));
        emit(enc_i(F3_ADD, 7, 7, -1));
        // x0 targets retire without a commit
        emit(enc_i(F3_ADD, 0, 1, 5));
        emit(enc_lui(0, 'h12345));
        emit(enc_r(0, F3_ADD, 8, 0, 1));
        emit(enc_i(F3_OR, 9, 0, 0));
        emit(HALT);
        end_test();

        begin_test("branches and JAL", 1'b0);
        load_branch_prog();
        end_test();

        begin_test("branches and JAL with bus stalls", 1'b1);
        load_branch_prog();
        end_test();

        $display("summary: %0d tests run, %0d failed, %0d mismatches",
                 test_num, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
// instruction fetch only over AXI4-Lite and RESET_PC must be word aligned
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter rv_isa_pkg::xlen_t RESET_PC = '0
) (
    input  wire                        clk,
    input  wire                        rst_n_i,
    output cpu_bus_pkg::axil_ar_t      ar_o,
    output logic                       arvalid_o,
    input  wire                        arready_i,
    input  wire cpu_bus_pkg::axil_r_t  r_i,
    input  wire                        rvalid_i,
    output logic                       rready_o,
    output cpu_bus_pkg::commit_t       commit_o
);

    cpu_bus_pkg::fetch_t   ifu_fetch;
    logic                  ifu_fetch_valid;
    logic                  idu_fetch_ready;
    rv_isa_pkg::reg_addr_t idu_rs1;
    rv_isa_pkg::reg_addr_t idu_rs2;
    rv_isa_pkg::dec_op_t   idu_dec;
    rv_isa_pkg::xlen_t     gpr_rdata1;
    rv_isa_pkg::xlen_t     gpr_rdata2;
    logic                  exu_redirect;
    rv_isa_pkg::xlen_t     exu_redirect_pc;
    logic                  exu_wb_we;
    rv_isa_pkg::reg_addr_t exu_wb_addr;
    rv_isa_pkg::xlen_t     exu_wb_data;

    ifu #(
        .RESET_PC(RESET_PC)
    ) u_ifu (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .redirect_i   (exu_redirect),
        .redirect_pc_i(exu_redirect_pc),
        .ar_o         (ar_o),
        .arvalid_o    (arvalid_o),
        .arready_i    (arready_i),
        .r_i          (r_i),
        .rvalid_i     (rvalid_i),
        .rready_o     (rready_o),
        .fetch_o      (ifu_fetch),
        .fetch_valid_o(ifu_fetch_valid),
        .fetch_ready_i(idu_fetch_ready)
    );

    idu u_idu (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .fetch_i      (ifu_fetch),
        .fetch_valid_i(ifu_fetch_valid),
        .fetch_ready_o(idu_fetch_ready),
        .redirect_i   (exu_redirect),
        .rs1_o        (idu_rs1),
        .rs2_o        (idu_rs2),
        .dec_o        (idu_dec)
    );

    // redirect goes straight back to fetch and decode
    exu u_exu (
        .dec_i        (idu_dec),
        .rs1_data_i   (gpr_rdata1),
        .rs2_data_i   (gpr_rdata2),
        .redirect_o   (exu_redirect),
        .redirect_pc_o(exu_redirect_pc),
        .wb_we_o      (exu_wb_we),
        .wb_addr_o    (exu_wb_addr),
        .wb_data_o    (exu_wb_data),
        .commit_o     (commit_o)
    );

    gpr u_gpr (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (exu_wb_we),
        .waddr_i (exu_wb_addr),
        .wdata_i (exu_wb_data),
        .raddr1_i(idu_rs1),
        .raddr2_i(idu_rs2),
        .rdata1_o(gpr_rdata1),
        .rdata2_o(gpr_rdata2)
    );

endmodule

`default_nettype wire

/* hw/exu.sv */
// single-cycle and purely combinational on the decode register with no stall path
`timescale 1ns/1ps
`default_nettype none

module exu (
    input  wire rv_isa_pkg::dec_op_t  dec_i,
    input  wire rv_isa_pkg::xlen_t    rs1_data_i,
    input  wire rv_isa_pkg::xlen_t    rs2_data_i,
    output logic                      redirect_o,
    output rv_isa_pkg::xlen_t         redirect_pc_o,
    output logic                      wb_we_o,
    output rv_isa_pkg::reg_addr_t     wb_addr_o,
    output rv_isa_pkg::xlen_t         wb_data_o,
    output cpu_bus_pkg::commit_t      commit_o
);

    rv_isa_pkg::xlen_t op_b;
    rv_isa_pkg::xlen_t alu_res;
    rv_isa_pkg::xlen_t link_pc;
    logic              rs_equal;
    logic              br_taken;

    assign op_b = dec_i.use_imm ? dec_i.imm : rs2_data_i;

    always_comb begin
        case (dec_i.alu_op)
            rv_isa_pkg::ALU_ADD:    alu_res = rs1_data_i + op_b;
            rv_isa_pkg::ALU_SUB:    alu_res = rs1_data_i - op_b;
            rv_isa_pkg::ALU_AND:    alu_res = rs1_data_i & op_b;
            rv_isa_pkg::ALU_OR:     alu_res = rs1_data_i | op_b;
            rv_isa_pkg::ALU_XOR:    alu_res = rs1_data_i ^ op_b;
            rv_isa_pkg::ALU_SLT: begin
                alu_res = {31'd0, $signed(rs1_data_i) < $signed(op_b)};
            end
            rv_isa_pkg::ALU_PASS_B: alu_res = op_b;
            default:                alu_res = '0;
        endcase
    end

    // branches always compare the two registers
    assign rs_equal = (rs1_data_i == rs2_data_i);
    assign br_taken = dec_i.is_branch && (rs_equal ^ dec_i.branch_ne);

    assign link_pc       = dec_i.pc + 32'd4;
    assign redirect_o    = dec_i.valid && (dec_i.is_jal || br_taken);
    assign redirect_pc_o = dec_i.pc + dec_i.imm;

    assign wb_we_o   = dec_i.valid && dec_i.rd_we;
    assign wb_addr_o = dec_i.rd;
    assign wb_data_o = dec_i.is_jal ? link_pc : alu_res;

    assign commit_o = '{
        valid: wb_we_o,
        pc:    dec_i.pc,
        rd:    dec_i.rd,
        data:  wb_data_o
    };

    // target alignment relies on ifu pc and the decoded immediate together
    always_comb begin
        if (redirect_o) begin
            redirect_align_a: assert final (redirect_pc_o[1:0] == 2'b00);
        end
    end

endmodule

`default_nettype wire

/* hw/idu.sv */
// never stalls except on redirect so the decode register is refilled or emptied every cycle
`timescale 1ns/1ps
`default_nettype none

module idu (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire cpu_bus_pkg::fetch_t    fetch_i,
    input  wire                         fetch_valid_i,
    output logic                        fetch_ready_o,
    input  wire                         redirect_i,
    output rv_isa_pkg::reg_addr_t       rs1_o,
    output rv_isa_pkg::reg_addr_t       rs2_o,
    output rv_isa_pkg::dec_op_t         dec_o
);

    rv_isa_pkg::rv_inst_u inst;
    rv_isa_pkg::xlen_t    imm_i;
    rv_isa_pkg::xlen_t    imm_b;
    rv_isa_pkg::xlen_t    imm_u;
    rv_isa_pkg::xlen_t    imm_j;
    rv_isa_pkg::alu_op_e  f3_alu;
    logic                 f3_ok;
    rv_isa_pkg::dec_op_t  dec_d;
    rv_isa_pkg::dec_op_t  dec_q;
    logic                 handoff;

    assign inst = fetch_i.inst;

    assign imm_i = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
    assign imm_b = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                    inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {inst.u_fmt.imm_31_12, 12'h000};
    assign imm_j = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                    inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

    // funct3 map common to OP and OP_IMM
    always_comb begin
        f3_ok = 1'b1;
        case (inst.r_fmt.funct3)
            rv_isa_pkg::F3_ADD_SUB: f3_alu = rv_isa_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLT:     f3_alu = rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::F3_XOR:     f3_alu = rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::F3_OR:      f3_alu = rv_isa_pkg::ALU_OR;
            rv_isa_pkg::F3_AND:     f3_alu = rv_isa_pkg::ALU_AND;
            default: begin
                f3_alu = rv_isa_pkg::ALU_ADD;
                f3_ok  = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec_d        = '0;
        dec_d.valid  = 1'b1;
        dec_d.pc     = fetch_i.pc;
        dec_d.rd     = inst.r_fmt.rd;
        dec_d.rs1    = inst.r_fmt.rs1;
        dec_d.rs2    = inst.r_fmt.rs2;
        dec_d.alu_op = rv_isa_pkg::ALU_ADD;
        case (inst.r_fmt.opcode)
            rv_isa_pkg::OPC_OP: begin
                dec_d.rd_we  = f3_ok;
                dec_d.alu_op = f3_alu;
                if (inst.r_fmt.funct3 == rv_isa_pkg::F3_ADD_SUB &&
                    inst.r_fmt.funct7 == rv_isa_pkg::F7_SUB) begin
                    dec_d.alu_op = rv_isa_pkg::ALU_SUB;
                end
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                dec_d.rd_we   = f3_ok;
                dec_d.alu_op  = f3_alu;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = imm_i;
            end
            rv_isa_pkg::OPC_LUI: begin
                dec_d.rd_we   = 1'b1;
                dec_d.alu_op  = rv_isa_pkg::ALU_PASS_B;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = imm_u;
            end
            rv_isa_pkg::OPC_JAL: begin
                dec_d.rd_we  = 1'b1;
                dec_d.is_jal = 1'b1;
                dec_d.imm    = imm_j;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                dec_d.is_branch = (inst.b_fmt.funct3 == rv_isa_pkg::F3_BEQ) ||
                                  (inst.b_fmt.funct3 == rv_isa_pkg::F3_BNE);
                dec_d.branch_ne = (inst.b_fmt.funct3 == rv_isa_pkg::F3_BNE);
                dec_d.imm       = imm_b;
            end
            default: begin
                // retires silently
                dec_d.rd_we = 1'b0;
            end
        endcase
        if (dec_d.rd == '0) begin
            dec_d.rd_we = 1'b0;
        end
    end

    assign fetch_ready_o = !redirect_i;
    assign handoff       = fetch_valid_i && fetch_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dec_q <= '0;
        end else begin
            dec_q <= handoff ? dec_d : '0;
        end
    end

    // gpr is read in execute off the decode register
    assign rs1_o = dec_q.rs1;
    assign rs2_o = dec_q.rs2;
    assign dec_o = dec_q;

endmodule

`default_nettype wire

/* hw/ifu.sv */
// one read outstanding at most and RESET_PC must be word aligned
`timescale 1ns/1ps
`default_nettype none

module ifu #(
    parameter rv_isa_pkg::xlen_t RESET_PC = '0
) (
    input  wire                           clk,
    input  wire                           rst_n_i,
    input  wire                           redirect_i,
    input  wire rv_isa_pkg::xlen_t        redirect_pc_i,
    output cpu_bus_pkg::axil_ar_t         ar_o,
    output logic                          arvalid_o,
    input  wire                           arready_i,
    input  wire cpu_bus_pkg::axil_r_t     r_i,
    input  wire                           rvalid_i,
    output logic                          rready_o,
    output cpu_bus_pkg::fetch_t           fetch_o,
    output logic                          fetch_valid_o,
    input  wire                           fetch_ready_i
);

    rv_isa_pkg::xlen_t   pc_q;
    rv_isa_pkg::xlen_t   pc_d;
    rv_isa_pkg::xlen_t   araddr_q;
    logic                arvalid_q;
    logic                outstanding_q;
    logic                discard_q;
    logic                buf_valid_q;
    cpu_bus_pkg::fetch_t buf_q;
    logic                ar_hs;
    logic                r_hs;
    logic                handoff;
    logic                in_flight;
    logic                issue;

    assign ar_hs     = arvalid_q && arready_i;
    assign r_hs      = rready_o && rvalid_i;
    assign handoff   = buf_valid_q && fetch_ready_i;
    assign in_flight = arvalid_q || outstanding_q;

    // next AR only once the buffer is free or being flushed
    assign issue = !in_flight && (!buf_valid_q || handoff || redirect_i);

    // a stale read keeps pc at the redirect target
    always_comb begin
        if (redirect_i) begin
            pc_d = redirect_pc_i;
        end else if (ar_hs && !discard_q) begin
            pc_d = pc_q + 32'd4;
        end else begin
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q          <= RESET_PC;
            arvalid_q     <= 1'b0;
            outstanding_q <= 1'b0;
            discard_q     <= 1'b0;
            buf_valid_q   <= 1'b0;
        end else begin
            pc_q <= pc_d;
            if (issue) begin
                arvalid_q <= 1'b1;
            end else if (ar_hs) begin
                arvalid_q <= 1'b0;
            end
            if (ar_hs) begin
                outstanding_q <= 1'b1;
            end else if (r_hs) begin
                outstanding_q <= 1'b0;
            end
            // beat returning in the redirect cycle is dropped by the flush below
            if (redirect_i && in_flight && !r_hs) begin
                discard_q <= 1'b1;
            end else if (r_hs) begin
                discard_q <= 1'b0;
            end
            if (redirect_i) begin
                buf_valid_q <= 1'b0;
            end else if (r_hs && !discard_q) begin
                buf_valid_q <= 1'b1;
            end else if (handoff) begin
                buf_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            araddr_q <= pc_d;
        end
        if (r_hs && !discard_q) begin
            buf_q <= '{pc: araddr_q, inst: r_i.data};
        end
    end

    assign ar_o          = '{addr: araddr_q, prot: cpu_bus_pkg::AR_PROT_INST};
    assign arvalid_o     = arvalid_q;
    assign rready_o      = outstanding_q && !buf_valid_q;
    assign fetch_o       = buf_q;
    assign fetch_valid_o = buf_valid_q;

    ar_stable_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o));

    r_okay_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        r_hs |-> r_i.resp == cpu_bus_pkg::RESP_OKAY);

    r_expected_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        rvalid_i |-> outstanding_q);

endmodule

`default_nettype wire

/* hw/gpr.sv */
// x0 reads as zero and ignores writes and a read in the write cycle returns the old value
`timescale 1ns/1ps
`default_nettype none

module gpr (
    input  wire                             clk,
    input  wire                             rst_n_i,
    input  wire                             we_i,
    input  wire rv_isa_pkg::reg_addr_t      waddr_i,
    input  wire rv_isa_pkg::xlen_t          wdata_i,
    input  wire rv_isa_pkg::reg_addr_t      raddr1_i,
    input  wire rv_isa_pkg::reg_addr_t      raddr2_i,
    output rv_isa_pkg::xlen_t               rdata1_o,
    output rv_isa_pkg::xlen_t               rdata2_o
);

    // no storage for x0
    rv_isa_pkg::xlen_t regs_q [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

`default_nettype wire

/* hw/cpu_bus_pkg.sv */
// AXI4-Lite read side only with 32-bit address and data and no IDs since one read is in flight
`default_nettype none

package cpu_bus_pkg;

    typedef struct packed {
        rv_isa_pkg::xlen_t addr;
        logic [2:0]        prot;
    } axil_ar_t;

    typedef struct packed {
        rv_isa_pkg::xlen_t data;
        logic [1:0]        resp;
    } axil_r_t;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // instruction access, secure, unprivileged
    localparam logic [2:0] AR_PROT_INST = 3'b100;

    typedef struct packed {
        rv_isa_pkg::xlen_t pc;
        rv_isa_pkg::xlen_t inst;
    } fetch_t;

    // one retired register write
    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::xlen_t     pc;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::xlen_t     data;
    } commit_t;

endpackage

`default_nettype wire

/* hw/rv_isa_pkg.sv */
// only the RV32I subset of this core is encoded here and other opcodes decode as no-ops
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // funct3 codes, shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // branch funct3 codes
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_SUB     = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_e     opcode;
    } i_fmt_t;

    // immediate bits scattered around the register fields
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        opcode_e    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } rv_inst_u;

    // contents of the decode register
    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        reg_addr_t rd;
        logic      rd_we;
        reg_addr_t rs1;
        reg_addr_t rs2;
        xlen_t     imm;
        alu_op_e   alu_op;
        logic      use_imm;
        logic      is_branch;
        logic      branch_ne;
        logic      is_jal;
    } dec_op_t;

endpackage

`default_nettype wire
